//--- bench/snake_input.txt
# cmd code(hex) count(dec) led(hex) game_over score(hex)
# key/badkey: count 1 starts the frame at a fixed step phase; scan: count 1 expects paused
check 00 0 00 0 0
sync 00 0 00 0 0
scan 00 1 00 0 0
wait_ticks 00 20 00 0 0
check 00 0 00 0 0
badkey 74 0 00 0 0
wait_ticks 00 3 00 0 0
check 00 0 00 0 0
key 29 0 29 0 0
badkey 6b 0 29 0 0
# Right along row 4 into the wall
key 74 0 74 0 0
wait_ticks 00 10 74 0 0
check 00 0 74 0 0
wait_ticks 00 3 74 0 0
check 00 0 74 1 0
scan 00 0 74 1 0
key 29 0 29 0 0
# Left is a reversal, up runs into the top wall
key 74 0 74 0 0
key 6b 0 6b 0 0
wait_ticks 00 1 6b 0 0
check 00 0 6b 0 0
key 75 0 75 0 0
wait_ticks 00 3 75 0 0
check 00 0 75 0 0
wait_ticks 00 3 75 0 0
check 00 0 75 1 0
key 29 0 29 0 0
# Three steps right, then up onto the first coin
key 74 1 74 0 0
key 75 1 75 0 0
wait_ticks 00 3 75 0 1
check 00 0 75 0 1
wait_ticks 00 4 75 1 1
check 00 0 75 1 1
key 29 0 29 0 0

//--- sim.f
hw/snake_pkg.sv
hw/ps2_rx.sv
hw/key_to_move.sv
hw/game_tick.sv
hw/vga_sync.sv
hw/snake_game.sv
hw/snake_top.sv
bench/tb_snake_top.sv

//--- Makefile
# Verilator simulation of the snake game testbench

VERILATOR ?= verilator
TOP       ?= tb_snake_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
BIN       ?= sim_bin
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(BIN)
	-./$(BUILD_DIR)/$(BIN) 2>&1 | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_snake_top.sv
`timescale 1ns/10ps

module tb_snake_top;
	import snake_pkg::*;

	localparam int TICK_CYCLES = 200;
	localparam int HALF_BIT    = 20;
	localparam int ALIGN_PHASE = 100;
	localparam int FRAME_CYC   = 2 * H_TOTAL * V_TOTAL;
	localparam int MAX_CMDS    = 64;

	logic               mclk;
	logic               rst_n;
	logic               ps2_clk;
	logic               ps2_data;
	logic [7:0]         led;
	logic               hsync;
	logic               vsync;
	rgb_t               rgb;
	logic               game_over;
	logic [SCORE_W-1:0] score;

	int cyc;
	int rel;
	int limit;
	int seed;
	int model_score;
	int n_cmds;

	logic [127:0] cmd_q   [MAX_CMDS];
	logic [31:0]  code_q  [MAX_CMDS];
	logic [31:0]  cnt_q   [MAX_CMDS];
	logic [31:0]  led_q   [MAX_CMDS];
	logic [31:0]  over_q  [MAX_CMDS];
	logic [31:0]  score_q [MAX_CMDS];

	snake_top #(
		.TICK_CYCLES (TICK_CYCLES)
	) u_snake_top (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.led       (led),
		.hsync     (hsync),
		.vsync     (vsync),
		.rgb       (rgb),
		.game_over (game_over),
		.score     (score)
	);

	initial begin
		mclk = 1'b0;
		forever #50 mclk = ~mclk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
	                         input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Step period shrinks with score, scaled to the bench base period
	function automatic int tick_period(input int s);
		int step;
		int floor_cyc;
		int p;
		step = TICK_CYCLES * TICK_STEP / TICK_BASE;
		if (step < 1)
			step = 1;
		floor_cyc = TICK_CYCLES * TICK_MIN / TICK_BASE;
		if (floor_cyc < 2)
			floor_cyc = 2;
		p = TICK_CYCLES - s * step;
		if (p < floor_cyc)
			p = floor_cyc;
		return p;
	endfunction

	// One frame, LSB first, odd parity unless corrupted
	task automatic send_ps2(input logic [7:0] b, input logic bad_parity);
		logic [10:0] bits;
		int gap;
		bits = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge mclk);
			ps2_data <= bits[i];
			repeat (HALF_BIT) @(posedge mclk);
			ps2_clk <= 1'b0;
			repeat (HALF_BIT) @(posedge mclk);
			ps2_clk <= 1'b1;
		end
		gap = 20 + int'({$random(seed)} % 32);
		@(posedge mclk);
		ps2_data <= 1'b1;
		repeat (gap) @(posedge mclk);
	endtask

	// Start a frame at a fixed phase of the step period
	task automatic align_to_tick();
		while ((cyc - rel) % TICK_CYCLES != ALIGN_PHASE)
			@(posedge mclk);
	endtask

	task automatic measure_sync();
		int n;
		while (hsync !== 1'b1) @(negedge mclk);
		while (hsync !== 1'b0) @(negedge mclk);
		n = 0;
		while (hsync === 1'b0) begin
			@(negedge mclk);
			n++;
		end
		check_val("hsync low width", n, 2 * H_SYNC);
		while (hsync === 1'b1) begin
			@(negedge mclk);
			n++;
		end
		check_val("hsync period", n, 2 * H_TOTAL);
		while (vsync !== 1'b1) @(negedge mclk);
		while (vsync !== 1'b0) @(negedge mclk);
		n = 0;
		while (vsync === 1'b0) begin
			@(negedge mclk);
			n++;
		end
		while (vsync === 1'b1) begin
			@(negedge mclk);
			n++;
		end
		check_val("vsync period", n, 2 * H_TOTAL * V_TOTAL);
	endtask

	task automatic scan_colors(input logic [31:0] expect_paused);
		logic seen_paused;
		logic seen_bg;
		seen_paused = 1'b0;
		seen_bg     = 1'b0;
		repeat (FRAME_CYC) begin
			@(negedge mclk);
			if (rgb == BG_PAUSED)
				seen_paused = 1'b1;
			if (rgb == BG_COLOR)
				seen_bg = 1'b1;
		end
		check_val("rgb BG_PAUSED seen", 32'(seen_paused), expect_paused);
		check_val("rgb BG_COLOR seen", 32'(seen_bg), 32'(expect_paused == 0));
	endtask

	task automatic load_commands();
		int fd;
		int n;
		int waits;
		int frames;
		int keys;
		string line;
		fd = $fopen("bench/snake_input.txt", "r");
		if (fd == 0)
			abort_run("could not open bench/snake_input.txt");
		n_cmds = 0;
		waits  = 0;
		frames = 0;
		keys   = 0;
		while (!$feof(fd) && n_cmds < MAX_CMDS) begin
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == 8'h23)
				continue;
			n = $sscanf(line, "%s %h %d %h %h %h", cmd_q[n_cmds], code_q[n_cmds],
			            cnt_q[n_cmds], led_q[n_cmds], over_q[n_cmds], score_q[n_cmds]);
			if (n != 6)
				continue;
			if (cmd_q[n_cmds] == "wait_ticks")
				waits += int'(cnt_q[n_cmds]);
			else if (cmd_q[n_cmds] == "scan")
				frames += 2;
			else if (cmd_q[n_cmds] == "sync")
				frames += 3;
			else if (cmd_q[n_cmds] == "key" || cmd_q[n_cmds] == "badkey")
				keys++;
			n_cmds++;
		end
		$fclose(fd);
		limit = waits * TICK_CYCLES + frames * FRAME_CYC + keys * 1000 + 20000;
	endtask

	// Run limit
	always @(negedge mclk) begin
		cyc <= cyc + 1;
		if (cyc > limit)
			abort_run("simulation timed out before the command list finished");
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		cyc         = 0;
		rel         = 0;
		seed        = 32'ha595;
		limit       = 32'h7fffffff;
		model_score = 0;
		rst_n       = 1'b0;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		load_commands();
		repeat (8) @(posedge mclk);
		rst_n <= 1'b1;
		rel = cyc;
		for (int i = 0; i < n_cmds; i++) begin
			if (cmd_q[i] == "key" || cmd_q[i] == "badkey") begin
				if (cnt_q[i] == 1)
					align_to_tick();
				send_ps2(code_q[i][7:0], cmd_q[i] == "badkey");
				check_val("led", 32'(led), led_q[i]);
				check_val("game_over", 32'(game_over), over_q[i]);
				check_val("score", 32'(score), score_q[i]);
				model_score = int'(score_q[i]);
			end else if (cmd_q[i] == "wait_ticks") begin
				repeat (int'(cnt_q[i]))
					repeat (tick_period(model_score)) @(posedge mclk);
			end else if (cmd_q[i] == "check") begin
				check_val("led", 32'(led), led_q[i]);
				check_val("game_over", 32'(game_over), over_q[i]);
				check_val("score", 32'(score), score_q[i]);
				model_score = int'(score_q[i]);
			end else if (cmd_q[i] == "sync") begin
				measure_sync();
			end else if (cmd_q[i] == "scan") begin
				scan_colors(cnt_q[i]);
			end else begin
				abort_run("unknown command in the stimulus file");
			end
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- hw/snake_top.sv
`timescale 1ns/10ps

module snake_top #(
	parameter int TICK_CYCLES = snake_pkg::TICK_BASE
) (
	input  logic                          mclk,
	input  logic                          rst_n,
	input  logic                          ps2_clk,
	input  logic                          ps2_data,
	output logic [7:0]                    led,
	output logic                          hsync,
	output logic                          vsync,
	output snake_pkg::rgb_t               rgb,
	output logic                          game_over,
	output logic [snake_pkg::SCORE_W-1:0] score
);
	import snake_pkg::*;

	logic [7:0] rx_byte;
	logic       rx_done;
	dir_t       move;
	dir_t       cur_dir;
	logic       move_stb;
	logic       pause_stb;
	logic       tick;
	pix_t       pos;
	logic       pix_en;
	vga_t       sync;
	vga_t       sync_d;
	rgb_t       game_color;
	logic       game_color_valid;
	logic       playing;
	logic       restart;
	logic       step;
	logic       game_move_stb;

	ps2_rx u_ps2_rx (
		.mclk     (mclk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_byte  (rx_byte),
		.rx_done  (rx_done)
	);

	key_to_move u_key_to_move (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.rx_byte   (rx_byte),
		.rx_done   (rx_done),
		.cur_dir   (cur_dir),
		.move      (move),
		.move_stb  (move_stb),
		.pause_stb (pause_stb)
	);

	game_tick #(
		.TICK_CYCLES (TICK_CYCLES)
	) u_game_tick (
		.mclk  (mclk),
		.rst_n (rst_n),
		.score (score),
		.tick  (tick)
	);

	vga_sync u_vga_sync (
		.mclk   (mclk),
		.rst_n  (rst_n),
		.pos    (pos),
		.pix_en (pix_en),
		.sync   (sync)
	);

	// Keys are ignored after a crash, space restarts
	assign restart       = pause_stb & game_over;
	assign step          = tick & ~game_over & playing;
	assign game_move_stb = move_stb & ~game_over;

	snake_game u_snake_game (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.restart     (restart),
		.step        (step),
		.move        (move),
		.move_stb    (game_move_stb),
		.pos         (pos),
		.cur_dir     (cur_dir),
		.game_over   (game_over),
		.score       (score),
		.color       (game_color),
		.color_valid (game_color_valid)
	);

	////////////////////////////////////////////////////////////
	// Play and pause
	////////////////////////////////////////////////////////////
	always_ff @(posedge mclk) begin
		if (!rst_n)
			playing <= 1'b0;
		else if (pause_stb)
			playing <= 1'b0;
		else if (game_move_stb)
			playing <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Output colour, sync delayed to match the game colour
	////////////////////////////////////////////////////////////
	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			sync_d <= '{hsync: 1'b1, vsync: 1'b1, visible: 1'b0};
			hsync  <= 1'b1;
			vsync  <= 1'b1;
			rgb    <= '0;
		end else begin
			sync_d <= sync;
			// Outputs change once per pixel
			if (pix_en) begin
				hsync <= sync_d.hsync;
				vsync <= sync_d.vsync;
				if (!sync_d.visible)
					rgb <= '0;
				else if (game_color_valid)
					rgb <= game_color;
				else if (!playing && !game_over)
					rgb <= BG_PAUSED;
				else
					rgb <= BG_COLOR;
			end
		end
	end

	assign led = rx_byte;

endmodule

//--- hw/snake_game.sv
`timescale 1ns/10ps

module snake_game (
	input  logic                          mclk,
	input  logic                          rst_n,
	input  logic                          restart,
	input  logic                          step,
	input  snake_pkg::dir_t               move,
	input  logic                          move_stb,
	input  snake_pkg::pix_t               pos,
	output snake_pkg::dir_t               cur_dir,
	output logic                          game_over,
	output logic [snake_pkg::SCORE_W-1:0] score,
	output snake_pkg::rgb_t               color,
	output logic                          color_valid
);
	import snake_pkg::*;

	localparam int LW    = $clog2(MAX_LEN + 1);
	localparam int CS    = $clog2(CELL_PX);
	localparam int BOX_R = BOX_X + GRID_W * CELL_PX;
	localparam int BOX_T = BOX_Y + GRID_H * CELL_PX;

	cell_t       body [MAX_LEN];
	logic [LW-1:0] len;
	dir_t        next_dir;
	cell_t       coin;
	logic        coin_pend;
	logic [15:0] lfsr;

	cell_t       new_head;
	logic        wall_hit;
	logic        self_hit;
	logic        eat;
	cell_t       cand;
	logic        cand_busy;

	logic        in_box;
	logic [9:0]  dx;
	logic [9:0]  dy;
	cell_t       pix_cell;
	logic        on_body;

	////////////////////////////////////////////////////////////
	// Next head and collisions
	////////////////////////////////////////////////////////////
	always_comb begin
		new_head = body[0];
		wall_hit = 1'b0;
		case (next_dir)
			DIR_UP: begin
				wall_hit   = (body[0].y == '0);
				new_head.y = body[0].y - 3'd1;
			end
			DIR_DOWN: begin
				wall_hit   = (body[0].y == 3'(GRID_H - 1));
				new_head.y = body[0].y + 3'd1;
			end
			DIR_LEFT: begin
				wall_hit   = (body[0].x == '0);
				new_head.x = body[0].x - 4'd1;
			end
			default: begin
				wall_hit   = (body[0].x == 4'(GRID_W - 1));
				new_head.x = body[0].x + 4'd1;
			end
		endcase
	end

	// Tail cell is free on this step, it moves away
	always_comb begin
		self_hit = 1'b0;
		for (int i = 0; i < MAX_LEN - 1; i++)
			if (i < int'(len) - 1 && body[i] == new_head)
				self_hit = 1'b1;
	end

	assign eat = !coin_pend && (new_head == coin);

	// Coin candidate from the LFSR, retried until it misses the snake
	assign cand = '{x: lfsr[3:0], y: lfsr[6:4]};

	always_comb begin
		cand_busy = 1'b0;
		for (int i = 0; i < MAX_LEN; i++)
			if (i < int'(len) && body[i] == cand)
				cand_busy = 1'b1;
	end

	always_ff @(posedge mclk) begin
		if (!rst_n)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	////////////////////////////////////////////////////////////
	// Game state
	////////////////////////////////////////////////////////////
	always_ff @(posedge mclk) begin
		if (!rst_n || restart) begin
			len       <= LW'(3);
			next_dir  <= DIR_RIGHT;
			cur_dir   <= DIR_RIGHT;
			game_over <= 1'b0;
			score     <= '0;
			coin      <= '{x: 4'(COIN0_X), y: 3'(COIN0_Y)};
			coin_pend <= 1'b0;
			// Heading right, body trails to the left
			body[0]   <= '{x: 4'(START_X), y: 3'(START_Y)};
			body[1]   <= '{x: 4'(START_X - 1), y: 3'(START_Y)};
			body[2]   <= '{x: 4'(START_X - 2), y: 3'(START_Y)};
		end else begin
			if (move_stb)
				next_dir <= move;
			if (step) begin
				cur_dir <= next_dir;
				if (wall_hit || self_hit) begin
					game_over <= 1'b1;
				end else begin
					for (int i = 1; i < MAX_LEN; i++)
						body[i] <= body[i-1];
					body[0] <= new_head;
					if (eat) begin
						score     <= score + 1'b1;
						coin_pend <= 1'b1;
						if (len < LW'(MAX_LEN))
							len <= len + LW'(1);
					end
				end
			end else if (coin_pend && !cand_busy) begin
				coin      <= cand;
				coin_pend <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel query, row 0 at the top of the box
	////////////////////////////////////////////////////////////
	assign in_box   = pos.x >= 10'(BOX_X) && pos.x < 10'(BOX_R) &&
	                  pos.y >= 10'(BOX_Y) && pos.y < 10'(BOX_T);
	assign dx       = pos.x - 10'(BOX_X);
	assign dy       = 10'(BOX_T - 1) - pos.y;
	assign pix_cell = '{x: 4'(dx >> CS), y: 3'(dy >> CS)};

	always_comb begin
		on_body = 1'b0;
		for (int i = 1; i < MAX_LEN; i++)
			if (i < int'(len) && body[i] == pix_cell)
				on_body = 1'b1;
	end

	always_ff @(posedge mclk) begin
		if (!rst_n)
			color_valid <= 1'b0;
		else
			color_valid <= in_box;
	end

	always_ff @(posedge mclk) begin
		if (pix_cell == body[0])
			color <= HEAD_COLOR;
		else if (on_body)
			color <= BODY_COLOR;
		else if (!coin_pend && pix_cell == coin)
			color <= COIN_COLOR;
		else
			color <= BOX_COLOR;
	end

	// A live step moves the head to a neighbouring cell, never across a grid edge
	assert property (@(posedge mclk) disable iff (!rst_n || restart)
		(step && !game_over) |=> game_over ||
		((int'(body[0].x) - int'($past(body[0].x))) ** 2 +
		 (int'(body[0].y) - int'($past(body[0].y))) ** 2 == 1));

endmodule

//--- hw/vga_sync.sv
`timescale 1ns/10ps

module vga_sync (
	input  logic            mclk,
	input  logic            rst_n,
	output snake_pkg::pix_t pos,
	output logic            pix_en,
	output snake_pkg::vga_t sync
);
	import snake_pkg::*;

	localparam int HS_START = H_VIS + H_FP;
	localparam int HS_END   = HS_START + H_SYNC;
	localparam int VS_START = V_VIS + V_FP;
	localparam int VS_END   = VS_START + V_SYNC;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	////////////////////////////////////////////////////////////
	// Counters, one pixel per two mclk
	////////////////////////////////////////////////////////////
	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			pix_en <= 1'b0;
			h_cnt  <= '0;
			v_cnt  <= '0;
		end else begin
			pix_en <= ~pix_en;
			if (pix_en) begin
				if (h_cnt == 10'(H_TOTAL - 1)) begin
					h_cnt <= '0;
					if (v_cnt == 10'(V_TOTAL - 1))
						v_cnt <= '0;
					else
						v_cnt <= v_cnt + 10'd1;
				end else begin
					h_cnt <= h_cnt + 10'd1;
				end
			end
		end
	end

	assign pos.x = h_cnt;
	// y counts up from the bottom line
	assign pos.y = 10'(V_VIS - 1) - v_cnt;

	assign sync.hsync   = !(h_cnt >= 10'(HS_START) && h_cnt < 10'(HS_END));
	assign sync.vsync   = !(v_cnt >= 10'(VS_START) && v_cnt < 10'(VS_END));
	assign sync.visible = (h_cnt < 10'(H_VIS)) && (v_cnt < 10'(V_VIS));

	// Sync pulses stay in the blanking windows
	assert property (@(posedge mclk) disable iff (!rst_n)
		(!sync.hsync || !sync.vsync) |-> !sync.visible);

endmodule

//--- hw/game_tick.sv
`timescale 1ns/10ps

module game_tick #(
	parameter int TICK_CYCLES = snake_pkg::TICK_BASE
) (
	input  logic                          mclk,
	input  logic                          rst_n,
	input  logic [snake_pkg::SCORE_W-1:0] score,
	output logic                          tick
);
	import snake_pkg::*;

	// Step and floor scale with the chosen base period
	localparam int STEP_RAW = TICK_CYCLES * TICK_STEP / TICK_BASE;
	localparam int MIN_RAW  = TICK_CYCLES * TICK_MIN / TICK_BASE;
	localparam int STEP_CYC = (STEP_RAW > 0) ? STEP_RAW : 1;
	localparam int MIN_CYC  = (MIN_RAW > 1) ? MIN_RAW : 2;
	localparam int CW       = $clog2(TICK_CYCLES + 1);

	logic [CW-1:0] cnt;
	logic [CW-1:0] period;
	logic [31:0]   cut;

	assign cut    = 32'(score) * 32'(STEP_CYC);
	assign period = (cut + 32'(MIN_CYC) >= 32'(TICK_CYCLES)) ? CW'(MIN_CYC) :
	                CW'(32'(TICK_CYCLES) - cut);

	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			cnt  <= CW'(TICK_CYCLES - 1);
			tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt  <= period - CW'(1);
			tick <= 1'b1;
		end else begin
			cnt  <= cnt - CW'(1);
			tick <= 1'b0;
		end
	end

endmodule

//--- hw/key_to_move.sv
`timescale 1ns/10ps

module key_to_move (
	input  logic            mclk,
	input  logic            rst_n,
	input  logic [7:0]      rx_byte,
	input  logic            rx_done,
	input  snake_pkg::dir_t cur_dir,
	output snake_pkg::dir_t move,
	output logic            move_stb,
	output logic            pause_stb
);
	import snake_pkg::*;

	logic brk;
	logic ext;
	logic is_arrow;
	dir_t key_dir;

	always_comb begin
		is_arrow = 1'b1;
		key_dir  = DIR_UP;
		case (rx_byte)
			KEY_UP:    key_dir = DIR_UP;
			KEY_DOWN:  key_dir = DIR_DOWN;
			KEY_LEFT:  key_dir = DIR_LEFT;
			KEY_RIGHT: key_dir = DIR_RIGHT;
			default:   is_arrow = 1'b0;
		endcase
	end

	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			brk       <= 1'b0;
			ext       <= 1'b0;
			move      <= DIR_RIGHT;
			move_stb  <= 1'b0;
			pause_stb <= 1'b0;
		end else begin
			move_stb  <= 1'b0;
			pause_stb <= 1'b0;
			if (rx_done) begin
				if (rx_byte == KEY_BREAK) begin
					brk <= 1'b1;
				end else if (rx_byte == KEY_EXT) begin
					ext <= 1'b1;
				end else begin
					brk <= 1'b0;
					ext <= 1'b0;
					// Make codes only; reversing onto the neck is dropped
					if (!brk && is_arrow && key_dir != dir_t'(cur_dir ^ 2'b10)) begin
						move     <= key_dir;
						move_stb <= 1'b1;
					end
					if (!brk && !ext && rx_byte == KEY_SPACE)
						pause_stb <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx (
	input  logic       mclk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] rx_byte,
	output logic       rx_done
);
	import snake_pkg::*;

	logic [1:0]  clk_sync;
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        clk_fall;
	logic [3:0]  bit_cnt;
	logic [9:0]  frame;
	logic [15:0] timer;
	logic        frame_ok;

	// Two flops on each line, idle high
	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	// frame holds start in bit 0, data in 8:1, parity in 9; stop is on the line now
	assign frame_ok = ~frame[0] & (^frame[9:1]) & data_sync[1];

	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			timer   <= '0;
			rx_done <= 1'b0;
			rx_byte <= '0;
		end else begin
			rx_done <= 1'b0;
			if (clk_fall) begin
				timer <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					rx_done <= frame_ok;
					if (frame_ok)
						rx_byte <= frame[8:1];
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != '0) begin
				// Stuck frame, start over
				if (timer == 16'(PS2_TIMEOUT)) begin
					bit_cnt <= '0;
					timer   <= '0;
				end else begin
					timer <= timer + 16'd1;
				end
			end
		end
	end

	always_ff @(posedge mclk) begin
		if (clk_fall && bit_cnt != 4'd10)
			frame <= {data_sync[1], frame[9:1]};
	end

	// A frame takes eleven PS/2 clocks, so a strobe is always isolated
	assert property (@(posedge mclk) disable iff (!rst_n) rx_done |=> !rx_done);

endmodule

//--- hw/snake_pkg.sv
package snake_pkg;

	////////////////////////////////////////////////////////////
	// Playfield and pacing
	////////////////////////////////////////////////////////////
	localparam int GRID_W    = 16;
	localparam int GRID_H    = 8;
	localparam int CELL_PX   = 8;
	localparam int BOX_X     = 64;
	localparam int BOX_Y     = 64;
	localparam int MAX_LEN   = 32;
	localparam int START_X   = 4;
	localparam int START_Y   = 4;
	localparam int COIN0_X   = 7;
	localparam int COIN0_Y   = 2;
	localparam int SCORE_W   = 6;
	localparam int TICK_BASE = 4096;
	localparam int TICK_STEP = 64;
	localparam int TICK_MIN  = 1024;

	// Coin placement sequence
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	// About 1 ms of mclk, drops a half received frame
	localparam int PS2_TIMEOUT = 50000;

	////////////////////////////////////////////////////////////
	// 640x480 screen timing, in pixels and lines
	////////////////////////////////////////////////////////////
	localparam int H_VIS   = 640;
	localparam int H_FP    = 16;
	localparam int H_SYNC  = 96;
	localparam int H_BP    = 48;
	localparam int H_TOTAL = H_VIS + H_FP + H_SYNC + H_BP;
	localparam int V_VIS   = 480;
	localparam int V_FP    = 10;
	localparam int V_SYNC  = 2;
	localparam int V_BP    = 33;
	localparam int V_TOTAL = V_VIS + V_FP + V_SYNC + V_BP;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		DIR_UP,
		DIR_RIGHT,
		DIR_DOWN,
		DIR_LEFT
	} dir_t;

	typedef struct packed {
		logic [3:0] x;
		logic [2:0] y;
	} cell_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} pix_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic visible;
	} vga_t;

	// Palette, RRRGGGBB
	localparam rgb_t HEAD_COLOR = 8'b111_000_11;
	localparam rgb_t BODY_COLOR = 8'b111_111_11;
	localparam rgb_t COIN_COLOR = 8'b001_111_01;
	localparam rgb_t BOX_COLOR  = 8'b100_100_10;
	localparam rgb_t BG_COLOR   = 8'b010_010_01;
	localparam rgb_t BG_PAUSED  = 8'b010_010_11;

	// Scan set 2 codes
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6b;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_SPACE = 8'h29;
	localparam logic [7:0] KEY_BREAK = 8'hf0;
	localparam logic [7:0] KEY_EXT   = 8'he0;

endpackage
